// File: sources.f
design/game_pkg.sv
design/stage_if.sv
design/piece_candidate.sv
design/collision_check.sv
design/piece_commit.sv
design/board_store.sv
design/board_top.sv
testbench/board_top_assert.sv
testbench/tb_board_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top \
    -f sources.f \
    -o sim_board_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_board_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: testbench/tb_board_top.sv
`timescale 1ns/1ns

module tb_board_top;

    import game_pkg::*;

    localparam int     BOARD_ROWS  = 20;
    localparam int     BOARD_COLS  = 10;
    localparam int     TIMEOUT_CYC = 10;
    localparam piece_t O_PIECE     = 16'h0066;
    localparam piece_t I_PIECE     = 16'h00F0;
    localparam piece_t L_PIECE     = 16'h0622;

    logic                   CLK;
    logic                   rst;
    logic                   cmd_valid;
    cmd_op_t                cmd_op;
    piece_t                 cmd_shape;
    logic [4:0]             read_row;
    logic                   result_valid;
    logic                   result_ok;
    logic [CLEAR_CNT_W-1:0] lines_cleared;
    logic                   piece_active;
    pos_t                   piece_row;
    pos_t                   piece_col;
    piece_t                 piece_shape;
    logic [BOARD_COLS-1:0]  row_data;

    // Reference model state
    logic [BOARD_COLS-1:0] ref_board [BOARD_ROWS];
    piece_t                ref_shape;
    int                    ref_row;
    int                    ref_col;
    bit                    ref_active;
    bit                    last_ok;
    integer                seed;

    board_top i_board_top (
        .CLK           (CLK),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_shape     (cmd_shape),
        .read_row      (read_row),
        .result_valid  (result_valid),
        .result_ok     (result_ok),
        .lines_cleared (lines_cleared),
        .piece_active  (piece_active),
        .piece_row     (piece_row),
        .piece_col     (piece_col),
        .piece_shape   (piece_shape),
        .row_data      (row_data)
    );

    bind board_top board_top_assert i_board_top_assert (
        .CLK           (CLK),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .result_valid  (result_valid),
        .result_ok     (result_ok),
        .lines_cleared (lines_cleared)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Old cell (r, c) lands on new cell (c, 3-r)
    function automatic piece_t rotate_cw(input piece_t s);
        piece_t t;
        t = '0;
        for (int r = 0; r < PIECE_DIM; r++)
            for (int c = 0; c < PIECE_DIM; c++)
                if (s[PIECE_DIM*r + c])
                    t[PIECE_DIM*c + (3 - r)] = 1'b1;
        return t;
    endfunction

    function automatic bit fits_board(input piece_t s, input int row, input int col);
        bit ok;
        int br;
        int bc;
        ok = 1'b1;
        for (int r = 0; r < PIECE_DIM; r++) begin
            for (int c = 0; c < PIECE_DIM; c++) begin
                br = row + r;
                bc = col + c;
                if (s[PIECE_DIM*r + c]) begin
                    if (bc < 0 || bc >= BOARD_COLS || br >= BOARD_ROWS)
                        ok = 1'b0;
                    else if (br >= 0 && ref_board[br][bc])
                        ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    // Merge the piece, then drop full rows and pack the rest down
    task automatic lock_into_board(output int lines);
        logic [BOARD_COLS-1:0] kept [BOARD_ROWS];
        int dst;
        lines = 0;
        dst = BOARD_ROWS - 1;
        for (int r = 0; r < PIECE_DIM; r++)
            for (int c = 0; c < PIECE_DIM; c++)
                if (ref_shape[PIECE_DIM*r + c])
                    ref_board[ref_row + r][ref_col + c] = 1'b1;
        for (int r = 0; r < BOARD_ROWS; r++)
            kept[r] = '0;
        for (int r = BOARD_ROWS - 1; r >= 0; r--) begin
            if (&ref_board[r]) begin
                lines++;
            end else begin
                kept[dst] = ref_board[r];
                dst--;
            end
        end
        for (int r = 0; r < BOARD_ROWS; r++)
            ref_board[r] = kept[r];
    endtask

    //////////////////////////////////////////////////
    // Checking and command helpers
    //////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic signed [31:0] got,
                             input logic signed [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                               $time, name, got, exp));
    endtask

    task automatic check_board();
        for (int r = 0; r < BOARD_ROWS; r++) begin
            read_row = 5'(r);
            #1;
            check_val($sformatf("row_data[%0d]", r), row_data, ref_board[r]);
        end
    endtask

    task automatic await_result();
        int cycles;
        cycles = 0;
        while (result_valid !== 1'b1) begin
            @(posedge CLK);
            #1;
            cycles++;
            if (cycles > TIMEOUT_CYC)
                fail_run("timeout: result_valid did not arrive within ten cycles");
        end
    endtask

    task automatic issue_cmd(input cmd_op_t op, input piece_t shape);
        piece_t nshape;
        int     nrow;
        int     ncol;
        int     lines;
        bit     ok;
        nshape = ref_shape;
        nrow = ref_row;
        ncol = ref_col;
        lines = 0;
        case (op)
            CMD_LOAD: begin
                nshape = shape;
                nrow = 0;
                ncol = BOARD_COLS / 2 - 2;
            end
            CMD_LEFT:      ncol = ref_col - 1;
            CMD_RIGHT:     ncol = ref_col + 1;
            CMD_DROP:      nrow = ref_row + 1;
            CMD_ROT_LEFT:  nshape = rotate_cw(rotate_cw(rotate_cw(ref_shape)));
            CMD_ROT_RIGHT: nshape = rotate_cw(ref_shape);
            default: ;
        endcase
        ok = fits_board(nshape, nrow, ncol) && (op == CMD_LOAD || ref_active);
        if (ok && op == CMD_LOCK) begin
            lock_into_board(lines);
            ref_active = 1'b0;
        end else if (ok) begin
            ref_shape = nshape;
            ref_row = nrow;
            ref_col = ncol;
            ref_active = 1'b1;
        end
        last_ok = ok;
        @(posedge CLK);
        #2;
        cmd_valid = 1'b1;
        cmd_op = op;
        cmd_shape = shape;
        @(posedge CLK);
        #2;
        cmd_valid = 1'b0;
        await_result();
        check_val("result_ok", result_ok, ok);
        check_val("lines_cleared", lines_cleared, lines);
        check_val("piece_active", piece_active, ref_active);
        check_val("piece_row", piece_row, ref_row);
        check_val("piece_col", piece_col, ref_col);
        check_val("piece_shape", piece_shape, ref_shape);
        check_board();
    endtask

    task automatic drop_to_rest();
        int n;
        n = 0;
        do begin
            issue_cmd(CMD_DROP, '0);
            n++;
        end while (last_ok && n <= BOARD_ROWS);
        if (last_ok)
            fail_run("a drop was never refused");
    endtask

    task automatic place_piece(input piece_t shape, input int target_col, output int landed);
        issue_cmd(CMD_LOAD, shape);
        while (ref_col > target_col && last_ok)
            issue_cmd(CMD_LEFT, '0);
        while (ref_col < target_col && last_ok)
            issue_cmd(CMD_RIGHT, '0);
        drop_to_rest();
        landed = piece_row;
        issue_cmd(CMD_LOCK, '0);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic after_reset_checks();
        check_val("piece_active", piece_active, 0);
        check_board();
        issue_cmd(CMD_LEFT, '0);
        check_val("left before load result_ok", result_ok, 0);
        issue_cmd(CMD_LOAD, O_PIECE);
        check_val("O load result_ok", result_ok, 1);
        check_val("O load piece_row", piece_row, 0);
        check_val("O load piece_col", piece_col, 3);
    endtask

    task automatic horizontal_moves();
        int moves;
        issue_cmd(CMD_LOAD, I_PIECE);
        moves = 0;
        do begin
            issue_cmd(CMD_LEFT, '0);
            if (last_ok)
                moves++;
        end while (last_ok && moves < BOARD_COLS);
        check_val("accepted left moves", moves, 3);
        check_val("piece_col after refused left", piece_col, 0);
        moves = 0;
        do begin
            issue_cmd(CMD_RIGHT, '0);
            if (last_ok)
                moves++;
        end while (last_ok && moves < BOARD_COLS);
        check_val("accepted right moves", moves, 6);
        check_val("piece_col after refused right", piece_col, 6);
    endtask

    task automatic rotations();
        issue_cmd(CMD_LOAD, L_PIECE);
        repeat (4) issue_cmd(CMD_ROT_RIGHT, '0);
        check_val("shape after four right turns", piece_shape, L_PIECE);
        issue_cmd(CMD_ROT_LEFT, '0);
        issue_cmd(CMD_ROT_RIGHT, '0);
        check_val("shape after left then right", piece_shape, L_PIECE);
    endtask

    task automatic drop_and_lock();
        issue_cmd(CMD_LOAD, O_PIECE);
        drop_to_rest();
        // Lowest O cell sits in box row 1
        check_val("piece_row at rest", piece_row, BOARD_ROWS - 2);
        issue_cmd(CMD_LOCK, '0);
        check_val("lines_cleared after lock", lines_cleared, 0);
        check_val("piece_active after lock", piece_active, 0);
        read_row = 5'd19;
        #1;
        check_val("row_data[19]", row_data, 10'h030);
    endtask

    task automatic line_clear();
        int landed;
        place_piece(O_PIECE, -1, landed);
        place_piece(O_PIECE, -1, landed);
        check_val("second O rest row", landed, BOARD_ROWS - 4);
        place_piece(O_PIECE, 1, landed);
        place_piece(O_PIECE, 5, landed);
        place_piece(O_PIECE, 7, landed);
        check_val("lines_cleared on full rows", lines_cleared, 2);
        for (int r = BOARD_ROWS - 2; r < BOARD_ROWS; r++) begin
            read_row = 5'(r);
            #1;
            check_val($sformatf("row_data[%0d] after shift", r), row_data, 10'h003);
        end
    endtask

    // Narrow column range, so some pieces must land on the stack
    task automatic stack_collision();
        int landed;
        int stacked;
        int target;
        stacked = 0;
        repeat (6) begin
            target = int'($unsigned($random(seed)) % 5) - 1;
            place_piece(O_PIECE, target, landed);
            if (landed < BOARD_ROWS - 2)
                stacked++;
        end
        check_val("pieces resting on the stack", stacked > 0, 1);
    endtask

    initial begin
        seed = 32'h0cf9_f0bc;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = CMD_LOAD;
        cmd_shape = '0;
        read_row = '0;
        ref_shape = '0;
        ref_row = 0;
        ref_col = 0;
        ref_active = 1'b0;
        last_ok = 1'b0;
        for (int r = 0; r < BOARD_ROWS; r++)
            ref_board[r] = '0;
        repeat (8) @(posedge CLK);
        #2;
        rst = 1'b0;
        after_reset_checks();
        horizontal_moves();
        rotations();
        drop_and_lock();
        line_clear();
        stack_collision();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: testbench/board_top_assert.sv
`timescale 1ns/1ns

module board_top_assert (
    input logic                             CLK,
    input logic                             rst,
    input logic                             cmd_valid,
    input game_pkg::cmd_op_t                cmd_op,
    input logic                             result_valid,
    input logic                             result_ok,
    input logic [game_pkg::CLEAR_CNT_W-1:0] lines_cleared
);

    import game_pkg::*;

    // No new command while one is still in the pipeline
    a_cmd_spacing: assert property (@(posedge CLK) disable iff (rst)
        cmd_valid |=> !cmd_valid ##1 !cmd_valid ##1 !cmd_valid)
        else $error("cmd_valid repeated within three cycles");

    // One register per stage, three stages to the result strobe
    a_result_latency: assert property (@(posedge CLK) disable iff (rst)
        cmd_valid |-> ##3 result_valid)
        else $error("result_valid missing after cmd_valid");

    a_result_pulse: assert property (@(posedge CLK) disable iff (rst)
        result_valid |=> !result_valid)
        else $error("result_valid longer than one cycle");

    // Cleared lines only come from a lock
    a_lines_on_lock: assert property (@(posedge CLK) disable iff (rst)
        (result_valid && lines_cleared != '0 && $past(cmd_op, 3) != CMD_LOCK) |-> !result_ok)
        else $error("lines_cleared nonzero on an accepted non-lock command");

endmodule

// File: design/board_top.sv
`timescale 1ns/1ns

module board_top #(
    parameter int BOARD_ROWS = 20,
    parameter int BOARD_COLS = 10
) (
    input  logic                             CLK,
    input  logic                             rst,
    input  logic                             cmd_valid,
    input  game_pkg::cmd_op_t                cmd_op,
    input  game_pkg::piece_t                 cmd_shape,
    input  logic [4:0]                       read_row,
    output logic                             result_valid,
    output logic                             result_ok,
    output logic [game_pkg::CLEAR_CNT_W-1:0] lines_cleared,
    output logic                             piece_active,
    output game_pkg::pos_t                   piece_row,
    output game_pkg::pos_t                   piece_col,
    output game_pkg::piece_t                 piece_shape,
    output logic [BOARD_COLS-1:0]            row_data
);

    import game_pkg::*;

    logic [BOARD_ROWS*BOARD_COLS-1:0] board_bits;
    logic [CLEAR_CNT_W-1:0]           cleared;
    logic                             fits;
    logic                             lock_we;

    stage_if cand_link ();
    stage_if check_link ();

    //////////////////////////////////////////////////
    // Three-stage command pipeline
    //////////////////////////////////////////////////

    piece_candidate #(
        .BOARD_ROWS (BOARD_ROWS),
        .BOARD_COLS (BOARD_COLS)
    ) i_piece_candidate (
        .CLK       (CLK),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_shape (cmd_shape),
        .cur_shape (piece_shape),
        .cur_row   (piece_row),
        .cur_col   (piece_col),
        .cand      (cand_link.src)
    );

    collision_check #(
        .BOARD_ROWS (BOARD_ROWS),
        .BOARD_COLS (BOARD_COLS)
    ) i_collision_check (
        .CLK        (CLK),
        .rst        (rst),
        .cand       (cand_link.dst),
        .board_bits (board_bits),
        .checked    (check_link.src),
        .fits       (fits)
    );

    piece_commit i_piece_commit (
        .CLK           (CLK),
        .rst           (rst),
        .checked       (check_link.dst),
        .fits          (fits),
        .cleared       (cleared),
        .cur_shape     (piece_shape),
        .cur_row       (piece_row),
        .cur_col       (piece_col),
        .piece_active  (piece_active),
        .lock_we       (lock_we),
        .result_valid  (result_valid),
        .result_ok     (result_ok),
        .lines_cleared (lines_cleared)
    );

    // A lock carries the committed piece unchanged
    board_store #(
        .BOARD_ROWS (BOARD_ROWS),
        .BOARD_COLS (BOARD_COLS)
    ) i_board_store (
        .CLK        (CLK),
        .rst        (rst),
        .lock_we    (lock_we),
        .lock_shape (piece_shape),
        .lock_row   (piece_row),
        .lock_col   (piece_col),
        .board_bits (board_bits),
        .cleared    (cleared),
        .read_row   (read_row),
        .row_data   (row_data)
    );

endmodule

// File: design/board_store.sv
`timescale 1ns/1ns

module board_store #(
    parameter int BOARD_ROWS = 20,
    parameter int BOARD_COLS = 10
) (
    input  logic                             CLK,
    input  logic                             rst,
    input  logic                             lock_we,
    input  game_pkg::piece_t                 lock_shape,
    input  game_pkg::pos_t                   lock_row,
    input  game_pkg::pos_t                   lock_col,
    output logic [BOARD_ROWS*BOARD_COLS-1:0] board_bits,
    output logic [game_pkg::CLEAR_CNT_W-1:0] cleared,
    input  logic [4:0]                       read_row,
    output logic [BOARD_COLS-1:0]            row_data
);

    import game_pkg::*;

    // Row 0 is the top, bit c of a row is column c
    logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_q;
    logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] merged;
    logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] packed_rows;
    logic [BOARD_ROWS-1:0]                 full;

    assign board_bits = board_q;
    assign row_data   = (read_row < BOARD_ROWS) ? board_q[read_row] : '0;

    //////////////////////////////////////////////////
    // Piece merge and full-row detect
    //////////////////////////////////////////////////

    always_comb begin
        int pr;
        int pc;
        merged = board_q;
        for (int r = 0; r < PIECE_DIM; r++) begin
            for (int c = 0; c < PIECE_DIM; c++) begin
                pr = int'(lock_row) + r;
                pc = int'(lock_col) + c;
                if (lock_we && lock_shape[PIECE_DIM*r + c] &&
                    pr >= 0 && pr < BOARD_ROWS && pc >= 0 && pc < BOARD_COLS) begin
                    merged[pr][pc] = 1'b1;
                end
            end
        end
    end

    always_comb begin
        cleared = '0;
        for (int r = 0; r < BOARD_ROWS; r++) begin
            full[r] = &merged[r];
            if (full[r]) begin
                cleared = cleared + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Compaction toward the floor
    //////////////////////////////////////////////////

    // Surviving rows keep their order, empty rows fill from the top
    always_comb begin
        int dst;
        packed_rows = '0;
        dst = BOARD_ROWS - 1;
        for (int src = BOARD_ROWS - 1; src >= 0; src--) begin
            if (!full[src]) begin
                packed_rows[dst] = merged[src];
                dst = dst - 1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            board_q <= '0;
        end else if (lock_we) begin
            board_q <= packed_rows;
        end
    end

endmodule

// File: design/piece_commit.sv
`timescale 1ns/1ns

module piece_commit (
    input  logic                             CLK,
    input  logic                             rst,
    stage_if.dst                             checked,
    input  logic                             fits,
    input  logic [game_pkg::CLEAR_CNT_W-1:0] cleared,
    output game_pkg::piece_t                 cur_shape,
    output game_pkg::pos_t                   cur_row,
    output game_pkg::pos_t                   cur_col,
    output logic                             piece_active,
    output logic                             lock_we,
    output logic                             result_valid,
    output logic                             result_ok,
    output logic [game_pkg::CLEAR_CNT_W-1:0] lines_cleared
);

    import game_pkg::*;

    logic accept;

    // Only a load may run without a live piece
    assign accept  = fits && (checked.op == CMD_LOAD || piece_active);

    // Board write happens at the same edge as the result
    assign lock_we = checked.valid && accept && checked.op == CMD_LOCK;

    always_ff @(posedge CLK) begin
        if (rst) begin
            result_valid  <= 1'b0;
            result_ok     <= 1'b0;
            lines_cleared <= '0;
            piece_active  <= 1'b0;
            cur_shape     <= '0;
            cur_row       <= '0;
            cur_col       <= '0;
        end else begin
            result_valid <= checked.valid;
            if (checked.valid) begin
                result_ok     <= accept;
                lines_cleared <= lock_we ? cleared : '0;
                if (accept) begin
                    if (checked.op == CMD_LOCK) begin
                        piece_active <= 1'b0;
                    end else begin
                        piece_active <= 1'b1;
                        cur_shape    <= checked.shape;
                        cur_row      <= checked.row;
                        cur_col      <= checked.col;
                    end
                end
            end
        end
    end

endmodule

// File: design/collision_check.sv
`timescale 1ns/1ns

module collision_check #(
    parameter int BOARD_ROWS = 20,
    parameter int BOARD_COLS = 10
) (
    input  logic                             CLK,
    input  logic                             rst,
    stage_if.dst                             cand,
    input  logic [BOARD_ROWS*BOARD_COLS-1:0] board_bits,
    stage_if.src                             checked,
    output logic                             fits
);

    import game_pkg::*;

    logic hit;

    //////////////////////////////////////////////////
    // Cell test against walls, floor and stack
    //////////////////////////////////////////////////

    always_comb begin
        int cell_r;
        int cell_c;
        hit = 1'b0;
        for (int r = 0; r < PIECE_DIM; r++) begin
            for (int c = 0; c < PIECE_DIM; c++) begin
                cell_r = int'(cand.row) + r;
                cell_c = int'(cand.col) + c;
                if (cand.shape[PIECE_DIM*r + c]) begin
                    if (cell_c < 0 || cell_c >= BOARD_COLS || cell_r >= BOARD_ROWS) begin
                        hit = 1'b1;
                    end else if (cell_r >= 0) begin
                        // Occupied board cell, row-major with col 0 at bit 0
                        if (board_bits[cell_r*BOARD_COLS + cell_c]) begin
                            hit = 1'b1;
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage two register
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            checked.valid <= 1'b0;
        end else begin
            checked.valid <= cand.valid;
        end
    end

    // Candidate goes on unchanged next to its verdict
    always_ff @(posedge CLK) begin
        if (cand.valid) begin
            checked.op    <= cand.op;
            checked.shape <= cand.shape;
            checked.row   <= cand.row;
            checked.col   <= cand.col;
            fits          <= ~hit;
        end
    end

endmodule

// File: design/piece_candidate.sv
`timescale 1ns/1ns

module piece_candidate #(
    parameter int BOARD_ROWS = 20,
    parameter int BOARD_COLS = 10
) (
    input  logic              CLK,
    input  logic              rst,
    input  logic              cmd_valid,
    input  game_pkg::cmd_op_t cmd_op,
    input  game_pkg::piece_t  cmd_shape,
    input  game_pkg::piece_t  cur_shape,
    input  game_pkg::pos_t    cur_row,
    input  game_pkg::pos_t    cur_col,
    stage_if.src              cand
);

    import game_pkg::*;

    // New pieces enter centred on the top row
    localparam pos_t SPAWN_COL = pos_t'(BOARD_COLS / 2 - 2);

    // Largest coordinate a pos_t can hold
    localparam int POS_MAX = 2 ** ($bits(pos_t) - 1) - 1;

    // Box cells past the far edge must still be addressable
    if (BOARD_ROWS + PIECE_DIM > POS_MAX || BOARD_COLS + PIECE_DIM > POS_MAX) begin : g_size_chk
        $error("board size exceeds the pos_t range");
    end

    // Quarter turn of the box, clockwise when cw is set
    function automatic piece_t rotate(input piece_t p, input logic cw);
        piece_t q;
        for (int r = 0; r < PIECE_DIM; r++) begin
            for (int c = 0; c < PIECE_DIM; c++) begin
                if (cw) begin
                    q[PIECE_DIM*r + c] = p[PIECE_DIM*(ROT_EDGE - c) + r];
                end else begin
                    q[PIECE_DIM*r + c] = p[PIECE_DIM*c + (ROT_EDGE - r)];
                end
            end
        end
        return q;
    endfunction

    //////////////////////////////////////////////////
    // Stage one register
    //////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (rst) begin
            cand.valid <= 1'b0;
        end else begin
            cand.valid <= cmd_valid;
        end
    end

    // Moves start from the committed piece
    always_ff @(posedge CLK) begin
        if (cmd_valid) begin
            cand.op    <= cmd_op;
            cand.shape <= cur_shape;
            cand.row   <= cur_row;
            cand.col   <= cur_col;
            case (cmd_op)
                CMD_LOAD: begin
                    cand.shape <= cmd_shape;
                    cand.row   <= '0;
                    cand.col   <= SPAWN_COL;
                end
                CMD_LEFT:      cand.col   <= cur_col - pos_t'(1);
                CMD_RIGHT:     cand.col   <= cur_col + pos_t'(1);
                CMD_DROP:      cand.row   <= cur_row + pos_t'(1);
                CMD_ROT_LEFT:  cand.shape <= rotate(cur_shape, 1'b0);
                CMD_ROT_RIGHT: cand.shape <= rotate(cur_shape, 1'b1);
                // Lock checks the piece where it stands
                default: ;
            endcase
        end
    end

endmodule

// File: design/stage_if.sv
`timescale 1ns/1ns

// One candidate command moving between two pipeline stages
interface stage_if;

    import game_pkg::*;

    logic    valid;
    cmd_op_t op;
    piece_t  shape;
    pos_t    row;
    pos_t    col;

    // Producing stage
    modport src (
        output valid, op, shape, row, col
    );

    // Consuming stage
    modport dst (
        input valid, op, shape, row, col
    );

endinterface

// File: design/game_pkg.sv
package game_pkg;

    //////////////////////////////////////////////////
    // Piece box geometry
    //////////////////////////////////////////////////

    // Edge of the square piece box
    localparam int PIECE_DIM = 4;

    // Cells in one box
    localparam int PIECE_CELLS = PIECE_DIM * PIECE_DIM;

    // Highest box row or column index, used by the rotations
    localparam int ROT_EDGE = PIECE_DIM - 1;

    // Width of the cleared-lines count (at most four rows per lock)
    localparam int CLEAR_CNT_W = 3;

    //////////////////////////////////////////////////
    // Command and piece types
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CMD_LOAD      = 3'd0,
        CMD_LEFT      = 3'd1,
        CMD_RIGHT     = 3'd2,
        CMD_DROP      = 3'd3,
        CMD_ROT_LEFT  = 3'd4,
        CMD_ROT_RIGHT = 3'd5,
        CMD_LOCK      = 3'd6
    } cmd_op_t;

    // Bit 4*row + col of the box, row 0 on top, col 0 on the left
    typedef logic [PIECE_CELLS-1:0] piece_t;

    // Board row or column of the box's top-left cell
    typedef logic signed [5:0] pos_t;

endpackage
